/* Makefile */
# Verilator build and run of the read-fill engine testbench

VERILATOR ?= verilator
TOP       ?= tb_fill_readout
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the simulator exits with a failing status on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* common/fill_pkg.sv */
// shared types of the read-fill engine
// state encoding, framer source select, fill header and tx beat

`include "fill_settings.svh"

package fill_pkg;

    // read-fill command FSM
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        CHK_FIFO = 4'd1,
        ERROR    = 4'd2,
        GET_HDR  = 4'd3,
        CSN_WAIT = 4'd4,
        CSN_SEND = 4'd5,
        CC_WAIT  = 4'd6,
        CC_SEND  = 4'd7,
        DATA     = 4'd8,
        DONE     = 4'd9
    } fill_state_e;

    // what the framer puts on the tx stream
    typedef enum logic [2:0] {
        SRC_NONE   = 3'd0,
        SRC_CSN    = 3'd1,
        SRC_CC     = 3'd2,
        SRC_INV_CC = 3'd3,
        SRC_DATA   = 3'd4
    } resp_src_e;

    // 152-bit fill header as stored in the header FIFO
    // burst_cnt already counts header and trailer bursts
    typedef struct packed {
        logic [`FILL_BURST_W-1:0] burst_cnt;
        logic [51:0]              rsv_hi;
        logic [`FILL_ADDR_W-1:0]  start_addr;
        logic [25:0]              rsv_mid;
        // set for an asynchronous fill, data then starts at burst 0
        logic                     async_mode;
        logic [25:0]              rsv_lo;
    } fill_header_t;

    // one word of the tx stream
    typedef struct packed {
        logic [`FILL_WORD_W-1:0] data;
        logic                    last;
    } tx_beat_t;

endpackage

/* common/fill_settings.svh */
// widths, burst buffer depth and command code for the read-fill engine

`ifndef FILL_SETTINGS_SVH
`define FILL_SETTINGS_SVH

// burst address and burst count widths as carried in the fill header
`define FILL_ADDR_W 23
`define FILL_BURST_W 24

// tx stream word
`define FILL_WORD_W 32

// words still to send, four words per burst
`define FILL_CNT_W (`FILL_BURST_W + 2)

// on-chip burst buffer, 64 bursts of 128 bits
`define FILL_BUF_AW 6
`define FILL_BUF_DEPTH (1 << `FILL_BUF_AW)
`define FILL_BURST_DATA_W 128
`define FILL_WORDS_PER_BURST 4

// read-fill command code, zero-extended to a word on the link
`define FILL_CC_RD 5'd8

`endif

/* fill_sm/fill_readout_sm.sv */
// read-fill command FSM
// checks the header FIFO, echoes csn/cc and steers the data phase

`timescale 1ns/10ps

`include "fill_settings.svh"

module fill_readout_sm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    output logic                      running,
    output logic                      done,
    input  logic                      hdr_empty,
    input  fill_pkg::fill_header_t    hdr_data,
    output logic                      hdr_rd_en,
    input  logic                      fixed_addr_en,
    input  logic [`FILL_ADDR_W-1:0]   fixed_addr,
    input  logic                      tx_ready,
    output fill_pkg::resp_src_e       resp_src,
    output logic                      tx_cmd_valid,
    output logic                      error_last,
    output logic                      rd_start,
    output logic [`FILL_ADDR_W-1:0]   rd_addr,
    output logic [`FILL_BURST_W-1:0]  rd_bursts,
    input  logic                      reader_idle,
    output logic                      load,
    output logic [`FILL_CNT_W-1:0]    load_count,
    input  logic                      count_zero
);

    import fill_pkg::*;

    fill_state_e state;
    fill_state_e state_next;
    resp_src_e   src_next;
    // set for the rest of a command once the header FIFO was found empty
    logic        error_found;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:     state_next = CHK_FIFO;
            // FWFT FIFO, header is already at the head if not empty
            CHK_FIFO: state_next = hdr_empty ? ERROR : GET_HDR;
            ERROR:    state_next = CSN_WAIT;
            GET_HDR:  state_next = CSN_WAIT;
            // hold until the downstream FIFO shows room
            CSN_WAIT: begin
                if (tx_ready) begin
                    state_next = CSN_SEND;
                end
            end
            CSN_SEND: state_next = CC_WAIT;
            CC_WAIT: begin
                if (tx_ready) begin
                    state_next = CC_SEND;
                end
            end
            // error packet ends with the inverted code
            CC_SEND:  state_next = error_found ? DONE : DATA;
            // all bursts issued and every word accepted
            DATA: begin
                if (reader_idle && count_zero) begin
                    state_next = DONE;
                end
            end
            DONE:     state_next = IDLE;
            default:  state_next = IDLE;
        endcase
        // dispatcher dropped run, abandon the command
        if (!run) begin
            state_next = IDLE;
        end
    end

    // framer source for the coming state
    always_comb begin
        unique case (state_next)
            CSN_WAIT, CSN_SEND: src_next = SRC_CSN;
            CC_WAIT, CC_SEND:   src_next = error_found ? SRC_INV_CC : SRC_CC;
            DATA:               src_next = SRC_DATA;
            default:            src_next = SRC_NONE;
        endcase
    end

    //////////////////////////////////////////////////
    // state and registered outputs
    //////////////////////////////////////////////////

    // outputs follow state_next so they line up with the state they belong to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            running      <= 1'b0;
            done         <= 1'b0;
            hdr_rd_en    <= 1'b0;
            load         <= 1'b0;
            tx_cmd_valid <= 1'b0;
            error_last   <= 1'b0;
            rd_start     <= 1'b0;
            resp_src     <= SRC_NONE;
        end else begin
            state        <= state_next;
            running      <= (state_next != IDLE);
            done         <= (state_next == DONE);
            // pop the header while it is latched
            hdr_rd_en    <= (state_next == GET_HDR);
            load         <= (state_next == GET_HDR);
            // one valid cycle per command word
            tx_cmd_valid <= (state_next == CSN_SEND) || (state_next == CC_SEND);
            error_last   <= (state_next == CC_SEND) && error_found;
            // single pulse on entry to the data phase
            rd_start     <= (state_next == DATA) && (state != DATA);
            resp_src     <= src_next;
        end
    end

    // error flag, cleared in IDLE and set in ERROR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_found <= 1'b0;
        end else if (state == IDLE) begin
            error_found <= 1'b0;
        end else if (state == ERROR) begin
            error_found <= 1'b1;
        end
    end

    // start address and sizes, latched from the head of the FIFO
    always_ff @(posedge clk) begin
        if (state_next == GET_HDR) begin
            if (fixed_addr_en) begin
                rd_addr <= fixed_addr;
            end else if (hdr_data.async_mode) begin
                rd_addr <= '0;
            end else begin
                rd_addr <= hdr_data.start_addr;
            end
            rd_bursts  <= hdr_data.burst_cnt;
            // 32-bit words, four per burst
            load_count <= {hdr_data.burst_cnt, 2'b00};
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // never pop an empty header FIFO
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) hdr_rd_en |-> !hdr_empty
    ) else $error("header FIFO popped while empty");

    // a command word only goes out after ready was seen
    a_cmd_after_ready: assert property (
        @(posedge clk) disable iff (!rst_n) tx_cmd_valid |-> $past(tx_ready)
    ) else $error("command word sent without a sampled tx_ready");

endmodule

/* src/fill_buffer_reader.sv */
// burst RAM with write port, burst fetch and 128-to-32 bit serializer

`timescale 1ns/10ps

`include "fill_settings.svh"

module fill_buffer_reader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          buf_wr_en,
    input  logic [`FILL_BUF_AW-1:0]       buf_wr_addr,
    input  logic [`FILL_BURST_DATA_W-1:0] buf_wr_data,
    input  logic                          rd_start,
    input  logic [`FILL_ADDR_W-1:0]       rd_addr,
    input  logic [`FILL_BURST_W-1:0]      rd_bursts,
    input  logic                          word_taken,
    output logic [`FILL_WORD_W-1:0]       word,
    output logic                          word_valid,
    output logic                          reader_idle
);

    logic [`FILL_BURST_DATA_W-1:0] mem [`FILL_BUF_DEPTH];

    // bursts not yet fetched
    logic [`FILL_BURST_W-1:0]      bursts_left;
    // next burst, wraps at the buffer depth
    logic [`FILL_BUF_AW-1:0]       ptr;
    logic [`FILL_BURST_DATA_W-1:0] hold;
    logic                          hold_valid;
    logic [1:0]                    word_idx;
    logic                          fetch;

    // write port, loaded by the testbench in place of the DDR3 writer
    always_ff @(posedge clk) begin
        if (buf_wr_en) begin
            mem[buf_wr_addr] <= buf_wr_data;
        end
    end

    // only fetch once the holding register has drained
    assign fetch = !hold_valid && (bursts_left != '0) && !rd_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bursts_left <= '0;
            ptr         <= '0;
            hold_valid  <= 1'b0;
            word_idx    <= '0;
        end else if (rd_start) begin
            bursts_left <= rd_bursts;
            // upper address bits fall outside the on-chip buffer
            ptr         <= rd_addr[`FILL_BUF_AW-1:0];
        end else if (fetch) begin
            bursts_left <= bursts_left - 1'b1;
            ptr         <= ptr + 1'b1;
            hold_valid  <= 1'b1;
            word_idx    <= '0;
        end else if (word_taken) begin
            if (word_idx == 2'(`FILL_WORDS_PER_BURST - 1)) begin
                hold_valid <= 1'b0;
            end
            word_idx <= word_idx + 1'b1;
        end
    end

    // synchronous RAM read straight into the holding register
    always_ff @(posedge clk) begin
        if (fetch) begin
            hold <= mem[ptr];
        end
    end

    // low word of the burst goes first
    assign word        = hold[word_idx*`FILL_WORD_W +: `FILL_WORD_W];
    assign word_valid  = hold_valid;
    assign reader_idle = (bursts_left == '0) && !hold_valid;

    // FSM only starts a read once the previous one has drained
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) rd_start |-> reader_idle
    ) else $error("read started while the reader was busy");

endmodule

/* src/fill_readout_top.sv */
// read-fill engine top level
// FSM, word counter, buffer reader and response framer

`timescale 1ns/10ps

`include "fill_settings.svh"

module fill_readout_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    output logic                          running,
    output logic                          done,
    input  logic [`FILL_WORD_W-1:0]       csn,
    input  logic [`FILL_WORD_W-1:0]       cc,
    input  logic                          hdr_empty,
    input  fill_pkg::fill_header_t        hdr_data,
    output logic                          hdr_rd_en,
    input  logic                          fixed_addr_en,
    input  logic [`FILL_ADDR_W-1:0]       fixed_addr,
    input  logic                          buf_wr_en,
    input  logic [`FILL_BUF_AW-1:0]       buf_wr_addr,
    input  logic [`FILL_BURST_DATA_W-1:0] buf_wr_data,
    output fill_pkg::tx_beat_t            tx_beat,
    output logic                          tx_valid,
    input  logic                          tx_ready
);

    import fill_pkg::*;

    // FSM controls
    resp_src_e                resp_src;
    logic                     tx_cmd_valid;
    logic                     error_last;
    logic                     rd_start;
    logic [`FILL_ADDR_W-1:0]  rd_addr;
    logic [`FILL_BURST_W-1:0] rd_bursts;
    logic                     load;
    logic [`FILL_CNT_W-1:0]   load_count;

    // status back to the FSM and framer
    logic                     reader_idle;
    logic                     count_zero;
    logic                     count_one;
    logic [`FILL_WORD_W-1:0]  word;
    logic                     word_valid;
    logic                     word_taken;

    fill_readout_sm i_fill_readout_sm (
        .clk, .rst_n, .run, .running, .done,
        .hdr_empty, .hdr_data, .hdr_rd_en,
        .fixed_addr_en, .fixed_addr, .tx_ready,
        .resp_src, .tx_cmd_valid, .error_last,
        .rd_start, .rd_addr, .rd_bursts, .reader_idle,
        .load, .load_count, .count_zero
    );

    // one decrement per accepted data word
    words_remaining_counter i_words_remaining_counter (
        .clk, .rst_n, .load, .load_count,
        .dec (word_taken),
        .count_zero, .count_one
    );

    fill_buffer_reader i_fill_buffer_reader (
        .clk, .rst_n, .buf_wr_en, .buf_wr_addr, .buf_wr_data,
        .rd_start, .rd_addr, .rd_bursts, .word_taken,
        .word, .word_valid, .reader_idle
    );

    response_framer i_response_framer (
        .clk, .rst_n, .resp_src, .csn, .cc,
        .tx_cmd_valid, .error_last, .word, .word_valid, .count_one,
        .tx_ready, .tx_beat, .tx_valid, .word_taken
    );

endmodule

/* src/response_framer.sv */
// tx word mux for csn, cc, inverted cc and fill data
// forms last and the data handshake

`timescale 1ns/10ps

`include "fill_settings.svh"

module response_framer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fill_pkg::resp_src_e     resp_src,
    input  logic [`FILL_WORD_W-1:0] csn,
    input  logic [`FILL_WORD_W-1:0] cc,
    input  logic                    tx_cmd_valid,
    input  logic                    error_last,
    input  logic [`FILL_WORD_W-1:0] word,
    input  logic                    word_valid,
    input  logic                    count_one,
    input  logic                    tx_ready,
    output fill_pkg::tx_beat_t      tx_beat,
    output logic                    tx_valid,
    output logic                    word_taken
);

    import fill_pkg::*;

    logic [`FILL_WORD_W-1:0] csn_q;
    logic [`FILL_WORD_W-1:0] cc_q;
    logic                    data_sel;

    // track the dispatcher while idle and freeze for the whole packet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csn_q <= '0;
            cc_q  <= '0;
        end else if (resp_src == SRC_NONE) begin
            csn_q <= csn;
            cc_q  <= cc;
        end
    end

    assign data_sel = (resp_src == SRC_DATA);

    always_comb begin
        // last marks the end of an error packet or the final fill word
        tx_beat.last = error_last || (data_sel && count_one);
        unique case (resp_src)
            SRC_CSN:    tx_beat.data = csn_q;
            SRC_CC:     tx_beat.data = cc_q;
            // error reply carries the inverted code
            SRC_INV_CC: tx_beat.data = ~cc_q;
            SRC_DATA:   tx_beat.data = word;
            default:    tx_beat.data = '0;
        endcase
    end

    // command words are strobed by the FSM and data moves on valid and ready
    assign tx_valid   = tx_cmd_valid || (data_sel && word_valid);
    assign word_taken = data_sel && word_valid && tx_ready;

endmodule

/* src/words_remaining_counter.sv */
// down-counter of fill words still to be accepted downstream

`timescale 1ns/10ps

`include "fill_settings.svh"

module words_remaining_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic [`FILL_CNT_W-1:0] load_count,
    input  logic                   dec,
    output logic                   count_zero,
    output logic                   count_one
);

    logic [`FILL_CNT_W-1:0] count;

    // load wins over an accepted word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_count;
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    assign count_zero = (count == '0);
    // next accepted word is the final one of the fill
    assign count_one  = (count == `FILL_CNT_W'(1));

    // reader and counter must agree on the word total
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) (dec && !load) |-> !count_zero
    ) else $error("word counter decremented at zero");

endmodule

/* tb.f */
+incdir+common
common/fill_pkg.sv
fill_sm/fill_readout_sm.sv
src/words_remaining_counter.sv
src/fill_buffer_reader.sv
src/response_framer.sv
src/fill_readout_top.sv
tb/tb_fill_readout.sv

/* tb/tb_fill_readout.sv */
// testbench for the read-fill engine
// clock, reset, header FIFO model, LFSR back-pressure and directed tests

`timescale 1ns/10ps

`include "fill_settings.svh"

module tb_fill_readout;

    import fill_pkg::*;

    // longest test is a few hundred cycles and the buffer preload takes 65
    localparam int TIMEOUT_CYCLES = 20000;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          run;
    logic                          running;
    logic                          done;
    logic [`FILL_WORD_W-1:0]       csn;
    logic [`FILL_WORD_W-1:0]       cc;
    logic                          hdr_empty = 1'b1;
    fill_header_t                  hdr_data = '0;
    logic                          hdr_rd_en;
    logic                          fixed_addr_en;
    logic [`FILL_ADDR_W-1:0]       fixed_addr;
    logic                          buf_wr_en;
    logic [`FILL_BUF_AW-1:0]       buf_wr_addr;
    logic [`FILL_BURST_DATA_W-1:0] buf_wr_data;
    tx_beat_t                      tx_beat;
    logic                          tx_valid;
    logic                          tx_ready = 1'b1;

    // header FIFO contents and expected tx beats
    fill_header_t hdr_q[$];
    tx_beat_t     exp_q[$];
    logic         pop_seen = 1'b0;
    logic         random_ready = 1'b0;
    logic [31:0]  lfsr = 32'h48a1_d1ca;
    int           cycle_count = 0;
    int           error_count = 0;

    fill_readout_top i_fill_readout_top (
        .clk, .rst_n, .run, .running, .done, .csn, .cc,
        .hdr_empty, .hdr_data, .hdr_rd_en, .fixed_addr_en, .fixed_addr,
        .buf_wr_en, .buf_wr_addr, .buf_wr_data,
        .tx_beat, .tx_valid, .tx_ready
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    // 32-bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        logic [31:0] s;
        s = state >> 1;
        if (state[0]) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    // word j of burst a is unique over the whole buffer
    function automatic logic [31:0] burst_word(input int addr, input int idx);
        logic [31:0] flat;
        flat = 32'((addr % `FILL_BUF_DEPTH) * `FILL_WORDS_PER_BURST + idx);
        return flat * 32'h9e37_79b1 + 32'h0bad_f00d;
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the DUT never finished its command");
        end
    end

    // FWFT header FIFO sees pops on the rising edge and updates on the falling edge
    always @(posedge clk) begin
        pop_seen = rst_n && hdr_rd_en;
    end

    always @(negedge clk) begin
        if (pop_seen) begin
            if (hdr_q.size() == 0) begin
                abort_run("the DUT popped the header FIFO while it was empty");
            end else begin
                void'(hdr_q.pop_front());
            end
        end
        hdr_empty = (hdr_q.size() == 0);
        if (hdr_q.size() == 0) begin
            hdr_data = '0;
        end else begin
            hdr_data = hdr_q[0];
        end
    end

    // downstream ready is random while back-pressure is on
    always @(negedge clk) begin
        if (random_ready) begin
            tx_ready = lfsr[0];
            lfsr = next_lfsr(lfsr);
        end else begin
            tx_ready = 1'b1;
        end
    end

    task automatic load_buffer();
        int a;
        int j;
        for (a = 0; a < `FILL_BUF_DEPTH; a++) begin
            @(negedge clk);
            buf_wr_en   = 1'b1;
            buf_wr_addr = `FILL_BUF_AW'(a);
            for (j = 0; j < `FILL_WORDS_PER_BURST; j++) begin
                buf_wr_data[j*32 +: 32] = burst_word(a, j);
            end
        end
        @(negedge clk);
        buf_wr_en = 1'b0;
    endtask

    task automatic push_header(input logic [22:0] addr, input logic [23:0] bursts,
                               input logic async_mode);
        fill_header_t h;
        // reserved fields carry junk the engine must ignore
        h            = '1;
        h.burst_cnt  = bursts;
        h.start_addr = addr;
        h.async_mode = async_mode;
        hdr_q.push_back(h);
    endtask

    task automatic expect_cmd(input logic [31:0] csn_val, input logic [31:0] cc_val,
                              input logic is_error);
        tx_beat_t b;
        b.data = csn_val;
        b.last = 1'b0;
        exp_q.push_back(b);
        // error reply ends with the inverted code
        b.data = is_error ? ~cc_val : cc_val;
        b.last = is_error;
        exp_q.push_back(b);
    endtask

    task automatic expect_fill(input int start, input int bursts);
        tx_beat_t b;
        int k;
        int j;
        for (k = 0; k < bursts; k++) begin
            for (j = 0; j < `FILL_WORDS_PER_BURST; j++) begin
                b.data = burst_word(start + k, j);
                b.last = (k == bursts - 1) && (j == `FILL_WORDS_PER_BURST - 1);
                exp_q.push_back(b);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // command driver and beat collector
    //////////////////////////////////////////////////

    task automatic run_command(input string name, input logic [31:0] csn_val,
                               input logic [31:0] cc_val, output int cycles, output int pops);
        tx_beat_t want;
        int       beat_idx;
        logic     prev_ready;
        logic     finished;
        @(negedge clk);
        csn = csn_val;
        cc  = cc_val;
        @(negedge clk);
        run        = 1'b1;
        cycles     = 0;
        pops       = 0;
        beat_idx   = 0;
        prev_ready = tx_ready;
        finished   = 1'b0;
        while (!finished) begin
            @(posedge clk);
            cycles++;
            if (hdr_rd_en) begin
                pops++;
            end
            // the first two beats are strobed command words and data also needs ready
            if (tx_valid && (beat_idx < 2 || tx_ready)) begin
                if (beat_idx < 2) begin
                    check_value({name, " cmd after ready"}, 64'(1), 64'(prev_ready));
                end
                if (exp_q.size() == 0) begin
                    abort_run({name, ": the DUT sent more beats than expected"});
                end else begin
                    want = exp_q.pop_front();
                    check_value({name, " beat"}, 64'(want), 64'(tx_beat));
                end
                beat_idx++;
            end
            prev_ready = tx_ready;
            finished   = done;
        end
        // drop run so the FSM stays in IDLE
        @(negedge clk);
        run = 1'b0;
        check_value({name, " beats missing"}, 64'(0), 64'(exp_q.size()));
        @(posedge clk);
        check_value({name, " done pulse"}, 64'(0), 64'(done));
        check_value({name, " running after"}, 64'(0), 64'(running));
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_error_packet();
        int cycles;
        int pops;
        @(posedge clk);
        check_value("reset running", 64'(0), 64'(running));
        check_value("reset done", 64'(0), 64'(done));
        check_value("reset tx_valid", 64'(0), 64'(tx_valid));
        check_value("reset hdr_rd_en", 64'(0), 64'(hdr_rd_en));
        expect_cmd(32'h0000_1001, 32'(`FILL_CC_RD), 1'b1);
        run_command("empty fifo", 32'h0000_1001, 32'(`FILL_CC_RD), cycles, pops);
        check_value("empty fifo pops", 64'(0), 64'(pops));
        // CHK_FIFO, ERROR, two cycles to each command word, then DONE
        check_value("empty fifo latency", 64'(8), 64'(cycles));
    endtask

    task automatic test_normal_fill();
        int cycles;
        int pops;
        push_header(23'd5, 24'd3, 1'b0);
        expect_cmd(32'h0000_2002, 32'(`FILL_CC_RD), 1'b0);
        expect_fill(5, 3);
        run_command("normal fill", 32'h0000_2002, 32'(`FILL_CC_RD), cycles, pops);
        check_value("normal fill pops", 64'(1), 64'(pops));
        check_value("normal fill fifo", 64'(0), 64'(hdr_q.size()));
    endtask

    task automatic test_async_mode();
        int cycles;
        int pops;
        push_header(23'd17, 24'd2, 1'b1);
        expect_cmd(32'h0000_3003, 32'(`FILL_CC_RD), 1'b0);
        expect_fill(0, 2);
        run_command("async mode", 32'h0000_3003, 32'(`FILL_CC_RD), cycles, pops);
        check_value("async mode pops", 64'(1), 64'(pops));
    endtask

    task automatic test_fixed_addr();
        int cycles;
        int pops;
        @(negedge clk);
        fixed_addr_en = 1'b1;
        // low bits select burst 62, so the fill runs 62, 63, 0
        fixed_addr    = 23'h2a_bcfe;
        push_header(23'd9, 24'd3, 1'b0);
        expect_cmd(32'h0000_4004, 32'(`FILL_CC_RD), 1'b0);
        expect_fill(int'(fixed_addr), 3);
        run_command("fixed addr", 32'h0000_4004, 32'(`FILL_CC_RD), cycles, pops);
        @(negedge clk);
        fixed_addr_en = 1'b0;
    endtask

    task automatic test_back_pressure();
        int cycles;
        int pops;
        @(posedge clk);
        random_ready = 1'b1;
        push_header(23'd40, 24'd4, 1'b0);
        expect_cmd(32'h0000_5005, 32'(`FILL_CC_RD), 1'b0);
        expect_fill(40, 4);
        run_command("back pressure", 32'h0000_5005, 32'(`FILL_CC_RD), cycles, pops);
        random_ready = 1'b0;
    endtask

    task automatic test_back_to_back();
        int cycles;
        int pops;
        push_header(23'd20, 24'd1, 1'b0);
        expect_cmd(32'hcafe_0001, 32'h0000_0008, 1'b0);
        expect_fill(20, 1);
        run_command("first of two", 32'hcafe_0001, 32'h0000_0008, cycles, pops);
        push_header(23'd33, 24'd2, 1'b0);
        expect_cmd(32'hbeef_0002, 32'h0000_0013, 1'b0);
        expect_fill(33, 2);
        run_command("second of two", 32'hbeef_0002, 32'h0000_0013, cycles, pops);
    endtask

    initial begin
        rst_n         = 1'b0;
        run           = 1'b0;
        csn           = '0;
        cc            = '0;
        fixed_addr_en = 1'b0;
        fixed_addr    = '0;
        buf_wr_en     = 1'b0;
        buf_wr_addr   = '0;
        buf_wr_data   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_error_packet();
        load_buffer();
        test_normal_fill();
        test_async_mode();
        test_fixed_addr();
        test_back_pressure();
        test_back_to_back();

        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checks failed");
        end
    end

endmodule
